// ==== design/sha512_core.sv ====
`default_nettype none

`include "sha512_params.svh"

module sha512_core (
	input wire CLK,
	input wire arst_n,
	input wire wr_en,
	input wire [`SHA512_WORD_W-1:0] in,
	input wire [`SHA512_ADDR_W-1:0] wr_addr,
	input wire set_input_ready,
	input wire sha512_pkg::sha512_blk_op_e input_blk_op,
	output logic ready,
	output logic [`SHA512_OUT_W-1:0] dout,
	output logic core_out_ready,
	output logic core_out_start,
	input wire rd_en
);

	// ****************************************
	// internal links
	// ****************************************

	sha512_in_if in_bus ();
	sha512_ctl_if ctl ();

	logic [`SHA512_WORD_W-1:0] wt;
	logic [`SHA512_WORD_W-1:0] dig [`SHA512_DIG_WORDS];
	logic dig_wr;
	logic out_busy;

	// ****************************************
	// blocks
	// ****************************************

	sha512_input_buf input_buf_inst (
		.CLK(CLK),
		.arst_n(arst_n),
		.wr_en(wr_en),
		.in(in),
		.wr_addr(wr_addr),
		.set_input_ready(set_input_ready),
		.input_blk_op(input_blk_op),
		.ready(ready),
		.bus(in_bus.buf_mp)
	);

	sha512_ctrl ctrl_inst (
		.CLK(CLK),
		.arst_n(arst_n),
		.in_bus(in_bus.ctrl_mp),
		.ctl(ctl.ctrl_mp),
		.out_busy(out_busy),
		.dig_wr(dig_wr)
	);

	sha512_schedule schedule_inst (
		.CLK(CLK),
		.arst_n(arst_n),
		.in_bus(in_bus.sched_mp),
		.ctl(ctl.sched_mp),
		.wt(wt)
	);

	sha512_round round_inst (
		.CLK(CLK),
		.arst_n(arst_n),
		.ctl(ctl.round_mp),
		.wt(wt),
		.dig(dig)
	);

	// digest leaves as 16 halves of 32 bits
	sha512_output_buf output_buf_inst (
		.CLK(CLK),
		.arst_n(arst_n),
		.dig_wr(dig_wr),
		.dig(dig),
		.out_busy(out_busy),
		.dout(dout),
		.core_out_ready(core_out_ready),
		.core_out_start(core_out_start),
		.rd_en(rd_en)
	);

endmodule

`default_nettype wire

// ==== design/sha512_ctrl.sv ====
`default_nettype none

`include "sha512_params.svh"

module sha512_ctrl (
	input wire CLK,
	input wire arst_n,
	sha512_in_if.ctrl_mp in_bus,
	sha512_ctl_if.ctrl_mp ctl,
	input wire out_busy,
	output logic dig_wr
);

	sha512_pkg::sha512_state_e state;
	logic [`SHA512_RND_W-1:0] rnd;
	// opcode decoded when the block is taken
	logic new_ctx_r;
	logic out_en;
	logic add_go;

	// add stage only waits if this block writes a busy output buffer
	assign add_go = (state == sha512_pkg::ST_ADD) && !(out_en && out_busy);

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= sha512_pkg::ST_IDLE;
			rnd <= '0;
			new_ctx_r <= 1'b0;
			out_en <= 1'b0;
		end else begin
			case (state)
			sha512_pkg::ST_IDLE: if (in_bus.pending) begin
				state <= sha512_pkg::ST_LOAD;
				new_ctx_r <= in_bus.op inside {sha512_pkg::OP_NEW_OUT, sha512_pkg::OP_NEW_HOLD};
				out_en <= in_bus.op inside {sha512_pkg::OP_NEW_OUT, sha512_pkg::OP_CONT_OUT};
			end
			sha512_pkg::ST_LOAD:
				state <= sha512_pkg::ST_ROUNDS;
			sha512_pkg::ST_ROUNDS: begin
				// counter wraps on the last round, ready for the next block
				if (rnd == `SHA512_ROUNDS - 1) begin
					rnd <= '0;
					state <= sha512_pkg::ST_ADD;
				end else begin
					rnd <= rnd + 1'b1;
				end
			end
			sha512_pkg::ST_ADD: if (add_go)
				state <= sha512_pkg::ST_IDLE;
			default:
				state <= sha512_pkg::ST_IDLE;
			endcase
		end
	end

	assign ctl.load = (state == sha512_pkg::ST_LOAD);
	assign ctl.new_ctx = new_ctx_r;
	assign ctl.rnd_en = (state == sha512_pkg::ST_ROUNDS);
	assign ctl.rnd = rnd;
	assign ctl.add = add_go;
	assign dig_wr = add_go && out_en;

	// rounds 0..15 read the block straight from the store
	assign in_bus.rd_addr = rnd[`SHA512_ADDR_W-1:0];
	assign in_bus.buf_release = ctl.rnd_en && (rnd == `SHA512_RELEASE_RND);

	a_rnd_in_range: assert property (@(posedge CLK) disable iff (!arst_n)
		state == sha512_pkg::ST_ROUNDS |-> rnd <= `SHA512_ROUNDS - 1);

	// load is followed by exactly 80 round cycles, then the add stage
	a_rounds_then_add: assert property (@(posedge CLK) disable iff (!arst_n)
		ctl.load |=> ctl.rnd_en [*`SHA512_ROUNDS] ##1 (state == sha512_pkg::ST_ADD));

endmodule

`default_nettype wire

// ==== design/sha512_if.sv ====
`default_nettype none

`include "sha512_params.svh"

// input buffer to control and schedule
interface sha512_in_if;
	// block submitted and not yet released
	logic pending;
	sha512_pkg::sha512_blk_op_e op;
	// async read port of the block store
	logic [`SHA512_WORD_W-1:0] word;
	logic [`SHA512_ADDR_W-1:0] rd_addr;
	// one cycle in the release round, frees the store
	logic buf_release;

	modport buf_mp (output pending, output op, output word, input rd_addr, input buf_release);
	modport ctrl_mp (input pending, input op, output rd_addr, output buf_release);
	modport sched_mp (input word);
endinterface

// control to schedule and round datapath
interface sha512_ctl_if;
	logic load;
	logic new_ctx;
	logic rnd_en;
	logic [`SHA512_RND_W-1:0] rnd;
	logic add;

	modport ctrl_mp (output load, output new_ctx, output rnd_en, output rnd, output add);
	modport sched_mp (input rnd_en, input rnd);
	modport round_mp (input load, input new_ctx, input rnd_en, input rnd, input add);
endinterface

`default_nettype wire

// ==== design/sha512_input_buf.sv ====
`default_nettype none

`include "sha512_params.svh"

module sha512_input_buf (
	input wire CLK,
	input wire arst_n,
	input wire wr_en,
	input wire [`SHA512_WORD_W-1:0] in,
	input wire [`SHA512_ADDR_W-1:0] wr_addr,
	// only meaningful together with wr_en, marks the last word
	input wire set_input_ready,
	input wire sha512_pkg::sha512_blk_op_e input_blk_op,
	output logic ready,
	sha512_in_if.buf_mp bus
);

	// 16 words of the block, message order
	logic [`SHA512_WORD_W-1:0] mem [`SHA512_BLK_WORDS];

	always_ff @(posedge CLK) begin
		if (wr_en)
			mem[wr_addr] <= in;
		// opcode travels with the last word
		if (wr_en && set_input_ready)
			bus.op <= input_blk_op;
	end

	// ready drops on the first word, comes back once the rounds no longer read the store
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			ready <= 1'b1;
			bus.pending <= 1'b0;
		end else begin
			if (wr_en)
				ready <= 1'b0;
			else if (bus.buf_release)
				ready <= 1'b1;

			if (wr_en && set_input_ready)
				bus.pending <= 1'b1;
			else if (bus.buf_release)
				bus.pending <= 1'b0;
		end
	end

	assign bus.word = mem[bus.rd_addr];

	// host must not overwrite a block the rounds still depend on
	a_no_wr_while_pending: assert property (@(posedge CLK) disable iff (!arst_n)
		bus.pending && !bus.buf_release |-> !wr_en);

endmodule

`default_nettype wire

// ==== design/sha512_output_buf.sv ====
`default_nettype none

`include "sha512_params.svh"

module sha512_output_buf (
	input wire CLK,
	input wire arst_n,
	input wire dig_wr,
	input wire [`SHA512_WORD_W-1:0] dig [`SHA512_DIG_WORDS],
	output logic out_busy,
	output logic [`SHA512_OUT_W-1:0] dout,
	output logic core_out_ready,
	output logic core_out_start,
	input wire rd_en
);

	// one index bit per half word
	localparam int IDX_W = $clog2(2 * `SHA512_DIG_WORDS);

	logic [`SHA512_WORD_W-1:0] mem [`SHA512_DIG_WORDS];
	logic [IDX_W-1:0] idx;
	logic [`SHA512_WORD_W-1:0] cur;

	always_ff @(posedge CLK) begin
		if (dig_wr)
			for (int i = 0; i < `SHA512_DIG_WORDS; i++)
				mem[i] <= dig[i];
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			core_out_ready <= 1'b0;
			idx <= '0;
		end else if (dig_wr) begin
			core_out_ready <= 1'b1;
			idx <= '0;
		end else if (rd_en && core_out_ready) begin
			// index wraps to 0 after the last half
			idx <= idx + 1'b1;
			if (idx == '1)
				core_out_ready <= 1'b0;
		end
	end

	// upper half of each word goes out first
	assign cur = mem[idx[IDX_W-1:1]];
	assign dout = idx[0] ? cur[`SHA512_OUT_W-1:0] : cur[`SHA512_WORD_W-1:`SHA512_OUT_W];
	assign core_out_start = core_out_ready && (idx == '0);
	assign out_busy = core_out_ready;

	// the add stage must hold off until the host has drained the last digest
	a_no_overwrite: assert property (@(posedge CLK) disable iff (!arst_n)
		dig_wr |-> !out_busy);

endmodule

`default_nettype wire

// ==== design/sha512_params.svh ====
`ifndef SHA512_PARAMS_SVH
`define SHA512_PARAMS_SVH

// message and state word width
`define SHA512_WORD_W      64
// host read width of the digest
`define SHA512_OUT_W       32
// words per 1024-bit block
`define SHA512_BLK_WORDS   16
`define SHA512_ROUNDS      80
`define SHA512_RND_W       7
`define SHA512_ADDR_W      4
`define SHA512_DIG_WORDS   8
// input buffer is free once this round starts
`define SHA512_RELEASE_RND 16

`endif

// ==== design/sha512_pkg.sv ====
`default_nettype none

`include "sha512_params.svh"

package sha512_pkg;

	// block operation
	// bit 1 selects continue, bit 0 selects hold
	typedef enum logic [1:0] {
		OP_NEW_OUT   = 2'd0,
		OP_NEW_HOLD  = 2'd1,
		OP_CONT_OUT  = 2'd2,
		OP_CONT_HOLD = 2'd3
	} sha512_blk_op_e;

	// block control states
	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_LOAD   = 2'd1,
		ST_ROUNDS = 2'd2,
		ST_ADD    = 2'd3
	} sha512_state_e;

	// ****************************************
	// constants
	// ****************************************

	// initial hash values H0..H7
	localparam logic [`SHA512_WORD_W-1:0] SHA512_IV [`SHA512_DIG_WORDS] = '{
		64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b, 64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
		64'h510e527fade682d1, 64'h9b05688c2b3e6c1f, 64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
	};

	// round constants, one per round
	localparam logic [`SHA512_WORD_W-1:0] SHA512_K [`SHA512_ROUNDS] = '{
		64'h428a2f98d728ae22, 64'h7137449123ef65cd, 64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
		64'h3956c25bf348b538, 64'h59f111f1b605d019, 64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
		64'hd807aa98a3030242, 64'h12835b0145706fbe, 64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
		64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1, 64'h9bdc06a725c71235, 64'hc19bf174cf692694,
		64'he49b69c19ef14ad2, 64'hefbe4786384f25e3, 64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
		64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483, 64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
		64'h983e5152ee66dfab, 64'ha831c66d2db43210, 64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
		64'hc6e00bf33da88fc2, 64'hd5a79147930aa725, 64'h06ca6351e003826f, 64'h142929670a0e6e70,
		64'h27b70a8546d22ffc, 64'h2e1b21385c26c926, 64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
		64'h650a73548baf63de, 64'h766a0abb3c77b2a8, 64'h81c2c92e47edaee6, 64'h92722c851482353b,
		64'ha2bfe8a14cf10364, 64'ha81a664bbc423001, 64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
		64'hd192e819d6ef5218, 64'hd69906245565a910, 64'hf40e35855771202a, 64'h106aa07032bbd1b8,
		64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53, 64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
		64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb, 64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
		64'h748f82ee5defb2fc, 64'h78a5636f43172f60, 64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
		64'h90befffa23631e28, 64'ha4506cebde82bde9, 64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
		64'hca273eceea26619c, 64'hd186b8c721c0c207, 64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
		64'h06f067aa72176fba, 64'h0a637dc5a2c898a6, 64'h113f9804bef90dae, 64'h1b710b35131c471b,
		64'h28db77f523047d84, 64'h32caab7b40c72493, 64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
		64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a, 64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817
	};

	// ****************************************
	// round functions
	// ****************************************

	// rotate right by n
	function automatic logic [`SHA512_WORD_W-1:0] rotr(
		input logic [`SHA512_WORD_W-1:0] x,
		input int unsigned n
	);
		return (x >> n) | (x << (`SHA512_WORD_W - n));
	endfunction

	// applied to a
	function automatic logic [`SHA512_WORD_W-1:0] big_sigma0(input logic [`SHA512_WORD_W-1:0] x);
		return rotr(x, 28) ^ rotr(x, 34) ^ rotr(x, 39);
	endfunction

	// applied to e
	function automatic logic [`SHA512_WORD_W-1:0] big_sigma1(input logic [`SHA512_WORD_W-1:0] x);
		return rotr(x, 14) ^ rotr(x, 18) ^ rotr(x, 41);
	endfunction

	// schedule, on W[t-15]
	function automatic logic [`SHA512_WORD_W-1:0] small_sigma0(
		input logic [`SHA512_WORD_W-1:0] x
	);
		return rotr(x, 1) ^ rotr(x, 8) ^ (x >> 7);
	endfunction

	// schedule, on W[t-2]
	function automatic logic [`SHA512_WORD_W-1:0] small_sigma1(
		input logic [`SHA512_WORD_W-1:0] x
	);
		return rotr(x, 19) ^ rotr(x, 61) ^ (x >> 6);
	endfunction

	function automatic logic [`SHA512_WORD_W-1:0] ch(
		input logic [`SHA512_WORD_W-1:0] x,
		input logic [`SHA512_WORD_W-1:0] y,
		input logic [`SHA512_WORD_W-1:0] z
	);
		return (x & y) ^ (~x & z);
	endfunction

	function automatic logic [`SHA512_WORD_W-1:0] maj(
		input logic [`SHA512_WORD_W-1:0] x,
		input logic [`SHA512_WORD_W-1:0] y,
		input logic [`SHA512_WORD_W-1:0] z
	);
		return (x & y) ^ (x & z) ^ (y & z);
	endfunction

endpackage

`default_nettype wire

// ==== design/sha512_round.sv ====
`default_nettype none

`include "sha512_params.svh"

module sha512_round (
	input wire CLK,
	input wire arst_n,
	sha512_ctl_if.round_mp ctl,
	input wire [`SHA512_WORD_W-1:0] wt,
	output logic [`SHA512_WORD_W-1:0] dig [`SHA512_DIG_WORDS]
);

	// working variables a..h as v[0]..v[7]
	logic [`SHA512_WORD_W-1:0] v [`SHA512_DIG_WORDS];
	// chaining digest
	logic [`SHA512_WORD_W-1:0] h_r [`SHA512_DIG_WORDS];
	logic [`SHA512_WORD_W-1:0] t1;
	logic [`SHA512_WORD_W-1:0] t2;

	assign t1 = v[7] + sha512_pkg::big_sigma1(v[4]) + sha512_pkg::ch(v[4], v[5], v[6])
		+ sha512_pkg::SHA512_K[ctl.rnd] + wt;
	assign t2 = sha512_pkg::big_sigma0(v[0]) + sha512_pkg::maj(v[0], v[1], v[2]);

	always_ff @(posedge CLK) begin
		if (ctl.load) begin
			// new block chain starts from IV, else continues from H
			for (int i = 0; i < `SHA512_DIG_WORDS; i++)
				v[i] <= ctl.new_ctx ? sha512_pkg::SHA512_IV[i] : h_r[i];
		end else if (ctl.rnd_en) begin
			v[0] <= t1 + t2;
			v[1] <= v[0];
			v[2] <= v[1];
			v[3] <= v[2];
			v[4] <= v[3] + t1;
			v[5] <= v[4];
			v[6] <= v[5];
			v[7] <= v[6];
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `SHA512_DIG_WORDS; i++)
				h_r[i] <= sha512_pkg::SHA512_IV[i];
		end else if (ctl.load && ctl.new_ctx) begin
			for (int i = 0; i < `SHA512_DIG_WORDS; i++)
				h_r[i] <= sha512_pkg::SHA512_IV[i];
		end else if (ctl.add) begin
			for (int i = 0; i < `SHA512_DIG_WORDS; i++)
				h_r[i] <= dig[i];
		end
	end

	// sum is always visible, output buffer samples it on the add edge
	always_comb begin
		for (int i = 0; i < `SHA512_DIG_WORDS; i++)
			dig[i] = h_r[i] + v[i];
	end

endmodule

`default_nettype wire

// ==== design/sha512_schedule.sv ====
`default_nettype none

`include "sha512_params.svh"

module sha512_schedule (
	input wire CLK,
	input wire arst_n,
	sha512_in_if.sched_mp in_bus,
	sha512_ctl_if.sched_mp ctl,
	output logic [`SHA512_WORD_W-1:0] wt
);

	// win[0] is W[t-16], win[15] is W[t-1]
	logic [`SHA512_WORD_W-1:0] win [`SHA512_BLK_WORDS];
	logic [`SHA512_WORD_W-1:0] w_next;

	// W[t] = ss1(W[t-2]) + W[t-7] + ss0(W[t-15]) + W[t-16]
	assign w_next = sha512_pkg::small_sigma1(win[14]) + win[9]
		+ sha512_pkg::small_sigma0(win[1]) + win[0];

	// first 16 rounds take the message itself
	assign wt = (ctl.rnd < `SHA512_BLK_WORDS) ? in_bus.word : w_next;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `SHA512_BLK_WORDS; i++)
				win[i] <= '0;
		end else if (ctl.rnd_en) begin
			// slide by one word per round
			for (int i = 0; i < `SHA512_BLK_WORDS - 1; i++)
				win[i] <= win[i + 1];
			win[`SHA512_BLK_WORDS - 1] <= wt;
		end
	end

endmodule

`default_nettype wire

// ==== dv/tb_sha512_core.sv ====
`default_nettype none

`include "sha512_params.svh"

module tb_sha512_core;

	localparam int HALF_PERIOD = 20;
	// inputs change this long after the rising edge
	localparam int DRIVE_DLY = 2;
	localparam int WAIT_LIMIT = 3000;

	logic CLK;
	logic arst_n;
	logic wr_en;
	logic [`SHA512_WORD_W-1:0] in;
	logic [`SHA512_ADDR_W-1:0] wr_addr;
	logic set_input_ready;
	sha512_pkg::sha512_blk_op_e input_blk_op;
	logic ready;
	logic [`SHA512_OUT_W-1:0] dout;
	logic core_out_ready;
	logic core_out_start;
	logic rd_en;

	// block being written, model chaining digest, expected digest words in output order
	logic [`SHA512_WORD_W-1:0] blk [`SHA512_BLK_WORDS];
	logic [`SHA512_WORD_W-1:0] model_h [`SHA512_DIG_WORDS];
	logic [`SHA512_WORD_W-1:0] exp_q [$];
	int errors;
	int timeouts;
	// upper bound of the random pause before the host drains a digest
	// the pause never drops below half of it
	int rd_gap_max;
	bit writer_done;

	sha512_core sha512_core_inst (
		.CLK(CLK),
		.arst_n(arst_n),
		.wr_en(wr_en),
		.in(in),
		.wr_addr(wr_addr),
		.set_input_ready(set_input_ready),
		.input_blk_op(input_blk_op),
		.ready(ready),
		.dout(dout),
		.core_out_ready(core_out_ready),
		.core_out_start(core_out_start),
		.rd_en(rd_en)
	);

	always #HALF_PERIOD CLK = ~CLK;

	// ****************************************
	// helpers
	// ****************************************

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	endtask

	task automatic abort_on_timeout(input string what);
		timeouts++;
		$display("timeout at %0t: %s", $time, what);
		finish_run();
	endtask

	task automatic check_eq(input logic [63:0] expected, input logic [63:0] actual,
		input string what);
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0t: %s, expected %h, got %h", $time, what, expected, actual);
		end
	endtask

	// all sampling and driving happens at this point of the cycle
	task automatic step_clock();
		@(posedge CLK);
		#DRIVE_DLY;
	endtask

	// ****************************************
	// reference model
	// ****************************************

	// one compression that chains per opcode and queues the digest of out blocks
	task automatic model_block(input sha512_pkg::sha512_blk_op_e op);
		logic [`SHA512_WORD_W-1:0] w [`SHA512_ROUNDS];
		logic [`SHA512_WORD_W-1:0] v [`SHA512_DIG_WORDS];
		logic [`SHA512_WORD_W-1:0] t1;
		logic [`SHA512_WORD_W-1:0] t2;
		if (op == sha512_pkg::OP_NEW_OUT || op == sha512_pkg::OP_NEW_HOLD)
			for (int i = 0; i < `SHA512_DIG_WORDS; i++)
				model_h[i] = sha512_pkg::SHA512_IV[i];
		for (int t = 0; t < `SHA512_ROUNDS; t++)
			w[t] = (t < `SHA512_BLK_WORDS) ? blk[t] : sha512_pkg::small_sigma1(w[t - 2])
				+ w[t - 7] + sha512_pkg::small_sigma0(w[t - 15]) + w[t - 16];
		for (int i = 0; i < `SHA512_DIG_WORDS; i++)
			v[i] = model_h[i];
		for (int t = 0; t < `SHA512_ROUNDS; t++) begin
			t1 = v[7] + sha512_pkg::big_sigma1(v[4]) + sha512_pkg::ch(v[4], v[5], v[6])
				+ sha512_pkg::SHA512_K[t] + w[t];
			t2 = sha512_pkg::big_sigma0(v[0]) + sha512_pkg::maj(v[0], v[1], v[2]);
			for (int i = `SHA512_DIG_WORDS - 1; i > 0; i--)
				v[i] = v[i - 1];
			v[4] = v[4] + t1;
			v[0] = t1 + t2;
		end
		for (int i = 0; i < `SHA512_DIG_WORDS; i++)
			model_h[i] = model_h[i] + v[i];
		if (op == sha512_pkg::OP_NEW_OUT || op == sha512_pkg::OP_CONT_OUT)
			for (int i = 0; i < `SHA512_DIG_WORDS; i++)
				exp_q.push_back(model_h[i]);
	endtask

	// ****************************************
	// host side
	// ****************************************

	// random block goes through the model first and then out as 16 writes
	// opcode rides on the last write
	task automatic submit_block(input sha512_pkg::sha512_blk_op_e op);
		int n;
		n = 0;
		for (int i = 0; i < `SHA512_BLK_WORDS; i++)
			blk[i] = {$urandom(), $urandom()};
		model_block(op);
		while (!ready) begin
			step_clock();
			n++;
			if (n > WAIT_LIMIT)
				abort_on_timeout("the input buffer never became ready for a new block");
		end
		for (int i = 0; i < `SHA512_BLK_WORDS; i++) begin
			wr_en = 1'b1;
			wr_addr = i[`SHA512_ADDR_W-1:0];
			in = blk[i];
			set_input_ready = (i == `SHA512_BLK_WORDS - 1);
			input_blk_op = op;
			step_clock();
		end
		wr_en = 1'b0;
		set_input_ready = 1'b0;
	endtask

	// until every expected digest is read and the core is idle again
	task automatic wait_drained();
		int n;
		n = 0;
		while (exp_q.size() != 0 || core_out_ready || !ready) begin
			step_clock();
			n++;
			if (n > WAIT_LIMIT)
				abort_on_timeout("the expected digests were never all read out");
		end
	endtask

	task automatic run_blocks();
		int len;
		// single blocks one at a time
		repeat (3) begin
			submit_block(sha512_pkg::OP_NEW_OUT);
			wait_drained();
		end
		// chains where only the last block outputs
		repeat (3) begin
			len = $urandom_range(4, 2);
			submit_block(sha512_pkg::OP_NEW_HOLD);
			for (int k = 1; k < len - 1; k++)
				submit_block(sha512_pkg::OP_CONT_HOLD);
			submit_block(sha512_pkg::OP_CONT_OUT);
			wait_drained();
		end
		// back to back with the next block written while the previous one computes
		repeat (4)
			submit_block(sha512_pkg::OP_NEW_OUT);
		wait_drained();
		// slow host stalls the add stage
		// a pause longer than one block time keeps the output buffer busy at the next add
		rd_gap_max = 200;
		repeat (3)
			submit_block(sha512_pkg::OP_NEW_OUT);
		submit_block(sha512_pkg::OP_NEW_HOLD);
		submit_block(sha512_pkg::OP_CONT_OUT);
		submit_block(sha512_pkg::OP_NEW_OUT);
		wait_drained();
	endtask

	// drains each digest as 16 halves and compares against the queue head
	task automatic read_digests();
		int n;
		int gap;
		bit done;
		bit has_exp;
		logic [`SHA512_WORD_W-1:0] word;
		logic [`SHA512_OUT_W-1:0] half;
		done = 1'b0;
		while (!done) begin
			n = 0;
			while (!core_out_ready && !(writer_done && exp_q.size() == 0)) begin
				step_clock();
				n++;
				if (n > WAIT_LIMIT)
					abort_on_timeout("no digest reached the output buffer");
			end
			if (!core_out_ready) begin
				done = 1'b1;
			end else begin
				has_exp = (exp_q.size() >= `SHA512_DIG_WORDS);
				if (!has_exp) begin
					errors++;
					$display("digest at %0t appeared although no block asked for one", $time);
				end
				gap = (rd_gap_max > 0) ? $urandom_range(rd_gap_max, rd_gap_max / 2) : 0;
				repeat (gap)
					step_clock();
				for (int i = 0; i < 2 * `SHA512_DIG_WORDS; i++) begin
					check_eq(1, core_out_ready, "core_out_ready during readout");
					check_eq((i == 0), core_out_start, "core_out_start");
					if (has_exp) begin
						word = exp_q[i / 2];
						// upper half first
						half = (i % 2 == 0) ? word[63:32] : word[31:0];
						check_eq(half, dout, $sformatf("digest half %0d", i));
					end
					rd_en = 1'b1;
					step_clock();
				end
				rd_en = 1'b0;
				check_eq(0, core_out_ready, "core_out_ready after 16 reads");
				if (has_exp)
					repeat (`SHA512_DIG_WORDS)
						void'(exp_q.pop_front());
			end
		end
	endtask

	// ****************************************
	// main sequence
	// ****************************************

	initial begin
		CLK = 1'b0;
		arst_n = 1'b0;
		wr_en = 1'b0;
		in = '0;
		wr_addr = '0;
		set_input_ready = 1'b0;
		input_blk_op = sha512_pkg::OP_NEW_OUT;
		rd_en = 1'b0;
		errors = 0;
		timeouts = 0;
		rd_gap_max = 0;
		writer_done = 1'b0;
		void'($urandom(98684));
		repeat (16)
			@(posedge CLK);
		#DRIVE_DLY;
		arst_n = 1'b1;
		step_clock();
		check_eq(1, ready, "ready after reset");
		check_eq(0, core_out_ready, "core_out_ready after reset");
		check_eq(0, core_out_start, "core_out_start after reset");
		fork
			begin
				run_blocks();
				writer_done = 1'b1;
			end
			read_digests();
		join
		check_eq(0, exp_q.size(), "digests left unread");
		check_eq(1, ready, "ready at end of run");
		finish_run();
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+design
design/sha512_pkg.sv
design/sha512_if.sv
design/sha512_input_buf.sv
design/sha512_ctrl.sv
design/sha512_schedule.sv
design/sha512_round.sv
design/sha512_output_buf.sv
design/sha512_core.sv
dv/tb_sha512_core.sv
